//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int XLEN       = 32;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	typedef logic [7:0] imem_addr_t; // word index into program memory

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	// alu funct3
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_t;

	typedef enum logic {A_RS1, A_PC} a_sel_t;
	typedef enum logic {B_RS2, B_IMM} b_sel_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;
	typedef enum logic [1:0] {SZ_B, SZ_H, SZ_W} mem_size_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
	} br_kind_t;

	typedef struct packed {
		alu_op_t   alu_op;
		a_sel_t    a_sel;
		b_sel_t    b_sel;
		wb_sel_t   wb_sel;
		logic      reg_we;
		logic      mem_re;
		logic      mem_we;
		mem_size_t mem_size;
		logic      mem_unsigned;
		br_kind_t  br_kind;
		logic      jalr; // target from alu, bit 0 cleared
	} ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] pc_plus4;
		logic [XLEN-1:0] instr;
	} fetch_t;

endpackage

`default_nettype wire

//--- rtl/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    redirect,
	input  logic [rv_pkg::XLEN-1:0] target,
	input  logic                    imem_we,
	input  rv_pkg::imem_addr_t      imem_addr,
	input  logic [rv_pkg::XLEN-1:0] imem_wdata,
	output rv_pkg::fetch_t          f
);
	import rv_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_next;
	logic [XLEN-1:0] imem [IMEM_WORDS];
	imem_addr_t      fetch_idx;

	assign pc_plus4  = pc + 32'd4;
	assign pc_next   = redirect ? target : pc_plus4;
	assign fetch_idx = pc[9:2]; // wraps over the program memory

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pc <= '0;
		else
			pc <= pc_next;
	end

	// load port, only used while the core is held in reset
	always_ff @(posedge clk)
	begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	assign f.pc       = pc;
	assign f.pc_plus4 = pc_plus4;
	assign f.instr    = imem[fetch_idx];

	// catches bad jalr or branch targets coming back from execute
	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
	input  rv_pkg::fetch_t          f,
	output logic [4:0]              rs1_addr,
	output logic [4:0]              rs2_addr,
	output logic [4:0]              rd_addr,
	output logic [rv_pkg::XLEN-1:0] imm,
	output rv_pkg::ctrl_t           ctrl
);
	import rv_pkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] i_imm;
	logic [XLEN-1:0] s_imm;
	logic [XLEN-1:0] b_imm;
	logic [XLEN-1:0] u_imm;
	logic [XLEN-1:0] j_imm;

	// sub only exists for register ops, sra for both
	function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt,
		input logic is_reg);
		alu_op_t op;
		case (f3)
			F3_ADD:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
			F3_SLL:  op = ALU_SLL;
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   op = ALU_OR;
			F3_AND:  op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	assign opcode   = f.instr[6:0];
	assign funct3   = f.instr[14:12];
	assign funct7   = f.instr[31:25];
	assign rd_addr  = f.instr[11:7];
	assign rs1_addr = f.instr[19:15];
	assign rs2_addr = f.instr[24:20];

	assign i_imm = {{20{f.instr[31]}}, f.instr[31:20]};
	assign s_imm = {{20{f.instr[31]}}, f.instr[31:25], f.instr[11:7]};
	assign b_imm = {{19{f.instr[31]}}, f.instr[31], f.instr[7], f.instr[30:25],
		f.instr[11:8], 1'b0};
	assign u_imm = {f.instr[31:12], 12'b0};
	assign j_imm = {{11{f.instr[31]}}, f.instr[31], f.instr[19:12], f.instr[20],
		f.instr[30:21], 1'b0};

	always_comb
	begin
		ctrl = '0; // add, rs1, rs2, alu writeback, nothing enabled
		imm  = '0;
		case (opcode)
			OP_LUI:
			begin
				ctrl.alu_op = ALU_PASS_B;
				ctrl.b_sel  = B_IMM;
				ctrl.reg_we = 1'b1;
				imm         = u_imm;
			end
			OP_AUIPC:
			begin
				ctrl.a_sel  = A_PC;
				ctrl.b_sel  = B_IMM;
				ctrl.reg_we = 1'b1;
				imm         = u_imm;
			end
			OP_JAL:
			begin
				ctrl.a_sel   = A_PC;
				ctrl.b_sel   = B_IMM;
				ctrl.wb_sel  = WB_PC4;
				ctrl.reg_we  = 1'b1;
				ctrl.br_kind = BR_JUMP;
				imm          = j_imm;
			end
			OP_JALR:
			begin
				ctrl.b_sel   = B_IMM;
				ctrl.wb_sel  = WB_PC4;
				ctrl.reg_we  = 1'b1;
				ctrl.br_kind = BR_JUMP;
				ctrl.jalr    = 1'b1;
				imm          = i_imm;
			end
			OP_BRANCH:
			begin
				case (funct3)
					F3_BEQ:  ctrl.br_kind = BR_EQ;
					F3_BNE:  ctrl.br_kind = BR_NE;
					F3_BLT:  ctrl.br_kind = BR_LT;
					F3_BGE:  ctrl.br_kind = BR_GE;
					F3_BLTU: ctrl.br_kind = BR_LTU;
					F3_BGEU: ctrl.br_kind = BR_GEU;
					default: ctrl.br_kind = BR_NONE;
				endcase
				imm = b_imm;
			end
			OP_LOAD, OP_STORE:
			begin
				ctrl.b_sel        = B_IMM;
				ctrl.mem_unsigned = funct3[2];
				case (funct3[1:0])
					2'b00:   ctrl.mem_size = SZ_B;
					2'b01:   ctrl.mem_size = SZ_H;
					default: ctrl.mem_size = SZ_W;
				endcase
				if (opcode == OP_LOAD)
				begin
					ctrl.wb_sel = WB_MEM;
					ctrl.reg_we = 1'b1;
					ctrl.mem_re = 1'b1;
					imm         = i_imm;
				end
				else
				begin
					ctrl.mem_we = 1'b1;
					imm         = s_imm;
				end
			end
			OP_IMM:
			begin
				ctrl.alu_op = alu_decode(funct3, funct7[5], 1'b0);
				ctrl.b_sel  = B_IMM;
				ctrl.reg_we = 1'b1;
				imm         = i_imm;
			end
			OP_REG:
			begin
				ctrl.alu_op = alu_decode(funct3, funct7[5], 1'b1);
				ctrl.reg_we = 1'b1;
			end
			default: ; // unknown opcodes fall through as a nop
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [4:0]              rs1_addr,
	input  logic [4:0]              rs2_addr,
	input  logic [4:0]              rd_addr,
	input  logic [4:0]              dbg_addr,
	input  logic                    we,
	input  logic [rv_pkg::XLEN-1:0] wdata,
	output logic [rv_pkg::XLEN-1:0] rs1_data,
	output logic [rv_pkg::XLEN-1:0] rs2_data,
	output logic [rv_pkg::XLEN-1:0] dbg_data
);
	import rv_pkg::*;

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && rd_addr != 5'd0) // x0 is never written
			regs[rd_addr] <= wdata;
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
	assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  rv_pkg::fetch_t          f,
	input  rv_pkg::ctrl_t           ctrl,
	input  logic [rv_pkg::XLEN-1:0] rs1_data,
	input  logic [rv_pkg::XLEN-1:0] rs2_data,
	input  logic [rv_pkg::XLEN-1:0] imm,
	output logic [rv_pkg::XLEN-1:0] alu_result,
	output logic                    redirect,
	output logic [rv_pkg::XLEN-1:0] target
);
	import rv_pkg::*;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [4:0]      shamt;
	logic [XLEN-1:0] br_target;
	logic            eq;
	logic            lt;
	logic            ltu;

	assign op_a  = (ctrl.a_sel == A_PC) ? f.pc : rs1_data;
	assign op_b  = (ctrl.b_sel == B_IMM) ? imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb
	begin
		case (ctrl.alu_op)
			ALU_SUB:    alu_result = op_a - op_b;
			ALU_SLL:    alu_result = op_a << shamt;
			ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:    alu_result = op_a ^ op_b;
			ALU_SRL:    alu_result = op_a >> shamt;
			ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
			ALU_OR:     alu_result = op_a | op_b;
			ALU_AND:    alu_result = op_a & op_b;
			ALU_PASS_B: alu_result = op_b; // lui
			default:    alu_result = op_a + op_b;
		endcase
	end

	// branch comparator always looks at the register operands
	assign eq  = rs1_data == rs2_data;
	assign lt  = $signed(rs1_data) < $signed(rs2_data);
	assign ltu = rs1_data < rs2_data;

	always_comb
	begin
		case (ctrl.br_kind)
			BR_EQ:   redirect = eq;
			BR_NE:   redirect = !eq;
			BR_LT:   redirect = lt;
			BR_GE:   redirect = !lt;
			BR_LTU:  redirect = ltu;
			BR_GEU:  redirect = !ltu;
			BR_JUMP: redirect = 1'b1;
			default: redirect = 1'b0;
		endcase
	end

	assign br_target = f.pc + imm;

	always_comb
	begin
		if (ctrl.jalr)
			target = {alu_result[XLEN-1:1], 1'b0};
		else if (ctrl.br_kind == BR_JUMP)
			target = alu_result; // jal, pc + imm from the alu
		else
			target = br_target;
	end

endmodule

`default_nettype wire

//--- rtl/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
	input  logic                    clk,
	input  logic                    rst_n,
	input  rv_pkg::ctrl_t           ctrl,
	input  logic [rv_pkg::XLEN-1:0] addr,
	input  logic [rv_pkg::XLEN-1:0] store_data,
	output logic [rv_pkg::XLEN-1:0] load_data
);
	import rv_pkg::*;

	logic [XLEN-1:0]    dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] word_idx;
	logic [1:0]         byte_off;
	logic [3:0]         lane_en;
	logic [XLEN-1:0]    store_lanes;
	logic [XLEN-1:0]    word_rd;
	logic [XLEN-1:0]    shifted;

	assign word_idx = addr[DMEM_AW+1:2]; // upper bits ignored
	assign byte_off = addr[1:0];
	assign word_rd  = dmem[word_idx];

	// replicate the store value so every lane sees it
	always_comb
	begin
		case (ctrl.mem_size)
			SZ_B:
			begin
				lane_en     = 4'b0001 << byte_off;
				store_lanes = {4{store_data[7:0]}};
			end
			SZ_H:
			begin
				lane_en     = 4'b0011 << byte_off;
				store_lanes = {2{store_data[15:0]}};
			end
			default:
			begin
				lane_en     = 4'b1111;
				store_lanes = store_data;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (ctrl.mem_we)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (lane_en[b])
					dmem[word_idx][8*b +: 8] <= store_lanes[8*b +: 8];
			end
		end
	end

	assign shifted = word_rd >> {byte_off, 3'b000}; // little endian lane to bit 0

	always_comb
	begin
		if (!ctrl.mem_re)
			load_data = '0;
		else
		begin
			case (ctrl.mem_size)
				SZ_B: load_data = ctrl.mem_unsigned ? {24'b0, shifted[7:0]}
					: {{24{shifted[7]}}, shifted[7:0]};
				SZ_H: load_data = ctrl.mem_unsigned ? {16'b0, shifted[15:0]}
					: {{16{shifted[15]}}, shifted[15:0]};
				default: load_data = word_rd;
			endcase
		end
	end

	// no trap for misaligned accesses, so the program must not issue them
	half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(ctrl.mem_re || ctrl.mem_we) && ctrl.mem_size == SZ_H |-> !addr[0]);
	word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(ctrl.mem_re || ctrl.mem_we) && ctrl.mem_size == SZ_W |-> addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    imem_we,
	input  rv_pkg::imem_addr_t      imem_addr,
	input  logic [rv_pkg::XLEN-1:0] imem_wdata,
	input  logic [4:0]              dbg_addr,
	output logic [rv_pkg::XLEN-1:0] pc,
	output logic [rv_pkg::XLEN-1:0] dbg_data
);
	import rv_pkg::*;

	fetch_t          f;
	ctrl_t           ctrl;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [4:0]      rd_addr;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] target;
	logic            redirect;
	logic [XLEN-1:0] load_data;
	logic [XLEN-1:0] wb_data;

	rv_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .redirect(redirect), .target(target),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata), .f(f)
	);

	rv_decode u_decode (
		.f(f), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
		.imm(imm), .ctrl(ctrl)
	);

	rv_regfile u_regfile (
		.clk(clk), .rst_n(rst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rd_addr(rd_addr), .dbg_addr(dbg_addr), .we(ctrl.reg_we), .wdata(wb_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .dbg_data(dbg_data)
	);

	rv_execute u_execute (
		.f(f), .ctrl(ctrl), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
		.alu_result(alu_result), .redirect(redirect), .target(target)
	);

	rv_lsu u_lsu (
		.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .addr(alu_result),
		.store_data(rs2_data), .load_data(load_data)
	);

	// write-back select
	always_comb
	begin
		case (ctrl.wb_sel)
			WB_MEM:  wb_data = load_data;
			WB_PC4:  wb_data = f.pc_plus4; // link for jal and jalr
			default: wb_data = alu_result;
		endcase
	end

	assign pc = f.pc;

endmodule

`default_nettype wire

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
	import rv_pkg::*;

	localparam int PROG_MAX = 64;
	localparam int RUN_ALU  = 30;
	localparam int RUN_FIB  = 280;
	localparam int RUN_MEM  = 30;
	localparam int RUN_BR   = 50;
	localparam int RUN_X0   = 20;
	localparam int FIB_N    = 50;
	// per test: program load, reset, run and up to 32 register reads
	localparam int CYCLE_LIMIT = (5 * (PROG_MAX + 3 + 32) + RUN_ALU + RUN_FIB + RUN_MEM
		+ RUN_BR + RUN_X0) * 3 / 2;

	logic            clk;
	logic            rst_n;
	logic            imem_we;
	imem_addr_t      imem_addr;
	logic [XLEN-1:0] imem_wdata;
	logic [4:0]      dbg_addr;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] dbg_data;

	logic [31:0] prog [$];
	logic [7:0]  dmem_ref [16]; // bytes at 0x100 and up
	integer      seed;
	int          cycles;
	int          checks;
	int          errors;
	int          tests;
	int          err_mark;
	int          fall_count;

	rv_core DUT (
		.clk(clk), .rst_n(rst_n), .imem_we(imem_we), .imem_addr(imem_addr),
		.imem_wdata(imem_wdata), .dbg_addr(dbg_addr), .pc(pc), .dbg_data(dbg_data)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic r_type(input int f7, input int f3, input int rd, input int rs1, input int rs2);
		prog.push_back({f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG});
	endtask

	task automatic i_type(input logic [6:0] op, input int f3, input int rd, input int rs1,
		input int imm);
		prog.push_back({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op});
	endtask

	task automatic s_type(input int f3, input int rs2, input int rs1, input int imm);
		prog.push_back({imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE});
	endtask

	task automatic b_type(input int f3, input int rs1, input int rs2, input int off);
		prog.push_back({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			OP_BRANCH});
	endtask

	task automatic u_type(input logic [6:0] op, input int rd, input logic [19:0] imm);
		prog.push_back({imm, rd[4:0], op});
	endtask

	task automatic j_type(input int rd, input int off);
		prog.push_back({off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL});
	endtask

	task automatic addi(input int rd, input int rs1, input int imm);
		i_type(OP_IMM, 0, rd, rs1, imm);
	endtask

	// lui + addi, upper part rounded for the sign of the low 12 bits
	task automatic load_const(input int rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		u_type(OP_LUI, rd, upper[31:12]);
		addi(rd, rd, value);
	endtask

	task automatic load_program();
		@(negedge clk);
		rst_n = 1'b0;
		for (int i = 0; i < prog.size(); i++)
		begin
			imem_we    = 1'b1;
			imem_addr  = i[7:0];
			imem_wdata = prog[i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic release_and_run(input int n);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (n) @(negedge clk);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("** Error %s: got 0x%08h, expected 0x%08h", name, got, expected);
		end
	endtask

	task automatic check_reg(input int idx, input string what, input logic [31:0] expected);
		@(negedge clk);
		dbg_addr = idx[4:0];
		#1;
		check($sformatf("x%0d (%s)", idx, what), dbg_data, expected);
	endtask

	task automatic begin_test();
		err_mark = errors;
		prog.delete();
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s finished with %0d errors", name, errors - err_mark);
	endtask

	function automatic logic branch_taken(input int f3, input logic [31:0] a, input logic [31:0] b);
		case (f3)
			0:       return a == b;
			1:       return a != b;
			4:       return $signed(a) < $signed(b);
			5:       return $signed(a) >= $signed(b);
			6:       return a < b;
			7:       return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// taken skips a marker in x31, not taken counts up x30
	task automatic branch_case(input int f3, input int rs1, input logic [31:0] a, input int rs2,
		input logic [31:0] b);
		b_type(f3, rs1, rs2, 8);
		if (branch_taken(f3, a, b))
			addi(31, 31, 1);
		else
		begin
			fall_count++;
			addi(30, 30, 1);
		end
	endtask

	task automatic store_case(input int f3, input int rs2, input int off, input logic [31:0] v);
		s_type(f3, rs2, 1, off);
		for (int k = 0; k < (1 << f3); k++)
			dmem_ref[off + k] = v[8*k +: 8]; // little endian
	endtask

	function automatic logic [31:0] load_ref(input int f3, input int off);
		case (f3)
			0:       return {{24{dmem_ref[off][7]}}, dmem_ref[off]};
			1:       return {{16{dmem_ref[off+1][7]}}, dmem_ref[off+1], dmem_ref[off]};
			4:       return {24'b0, dmem_ref[off]};
			5:       return {16'b0, dmem_ref[off+1], dmem_ref[off]};
			default: return {dmem_ref[off+3], dmem_ref[off+2], dmem_ref[off+1], dmem_ref[off]};
		endcase
	endfunction

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] simm;
		logic [4:0]  sh;
		int          imm;
		begin_test();
		a = $random(seed) | 32'h8000_0000; // negative, slt and sltu disagree
		b = $random(seed) & 32'h7fff_ffff;
		imm = $random(seed) % 2048;
		simm = imm;
		r = $random(seed);
		sh = r[4:0];
		load_const(1, a);
		load_const(2, b);
		r_type(0, 0, 3, 1, 2);
		r_type(32, 0, 4, 1, 2);
		r_type(0, 1, 5, 1, 2);
		r_type(0, 2, 6, 1, 2);
		r_type(0, 3, 7, 1, 2);
		r_type(0, 4, 8, 1, 2);
		r_type(0, 5, 9, 1, 2);
		r_type(32, 5, 10, 1, 2);
		r_type(0, 6, 11, 1, 2);
		r_type(0, 7, 12, 1, 2);
		r_type(0, 2, 22, 2, 1);
		r_type(0, 3, 23, 2, 1);
		for (int f3 = 0; f3 < 8; f3++)
			if (f3 != 1 && f3 != 5)
				i_type(OP_IMM, f3, 13 + f3, 1, imm);
		i_type(OP_IMM, 1, 24, 1, int'(sh));
		i_type(OP_IMM, 5, 25, 1, int'(sh));
		i_type(OP_IMM, 5, 26, 1, int'(sh) + 1024); // srai
		j_type(0, 0);
		load_program();
		release_and_run(RUN_ALU);
		check_reg(3, "add", a + b);
		check_reg(4, "sub", a - b);
		check_reg(5, "sll", a << b[4:0]);
		check_reg(6, "slt", ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		check_reg(7, "sltu", (a < b) ? 32'd1 : 32'd0);
		check_reg(8, "xor", a ^ b);
		check_reg(9, "srl", a >> b[4:0]);
		check_reg(10, "sra", $signed(a) >>> b[4:0]);
		check_reg(11, "or", a | b);
		check_reg(12, "and", a & b);
		check_reg(22, "slt swapped", ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		check_reg(23, "sltu swapped", (b < a) ? 32'd1 : 32'd0);
		check_reg(13, "addi", a + simm);
		check_reg(15, "slti", ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0);
		check_reg(16, "sltiu", (a < simm) ? 32'd1 : 32'd0);
		check_reg(17, "xori", a ^ simm);
		check_reg(19, "ori", a | simm);
		check_reg(20, "andi", a & simm);
		check_reg(24, "slli", a << sh);
		check_reg(25, "srli", a >> sh);
		check_reg(26, "srai", $signed(a) >>> sh);
		end_test("alu");
	endtask

	task automatic test_fibonacci();
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] t;
		logic [31:0] end_pc;
		begin_test();
		addi(1, 0, 1);
		addi(2, 0, 0);
		addi(3, 0, FIB_N);
		r_type(0, 0, 4, 1, 2); // loop
		addi(1, 2, 0);
		addi(2, 4, 0);
		addi(3, 3, -1);
		b_type(1, 3, 0, -16);
		end_pc = prog.size() * 4;
		j_type(0, 0);
		x = 0;
		y = 1;
		for (int i = 0; i < FIB_N; i++)
		begin
			t = x + y;
			x = y;
			y = t;
		end
		load_program();
		release_and_run(RUN_FIB);
		check_reg(4, "fib", x);
		check_reg(3, "count", 32'd0);
		check("pc", pc, end_pc);
		end_test("fibonacci");
	endtask

	task automatic test_load_store();
		int          ld_f3 [13] = '{2, 2, 2, 0, 4, 1, 5, 0, 4, 1, 5, 0, 5};
		int          ld_off [13] = '{0, 4, 8, 5, 5, 6, 6, 0, 3, 0, 2, 11, 10};
		logic [31:0] v;
		logic [31:0] hb;
		logic [31:0] hh;
		begin_test();
		v  = $random(seed) | 32'h80;
		hb = $random(seed) | 32'h80;
		hh = $random(seed) | 32'h8000;
		for (int i = 0; i < 16; i++)
			dmem_ref[i] = 8'h00;
		addi(1, 0, 256);
		load_const(2, v);
		load_const(3, hb);
		load_const(4, hh);
		store_case(2, 2, 0, v);
		store_case(0, 3, 5, hb);
		store_case(1, 4, 6, hh);
		store_case(0, 3, 2, hb);
		store_case(1, 4, 8, hh);
		store_case(0, 3, 11, hb);
		for (int i = 0; i < 13; i++)
			i_type(OP_LOAD, ld_f3[i], 10 + i, 1, ld_off[i]);
		j_type(0, 0);
		load_program();
		release_and_run(RUN_MEM);
		for (int i = 0; i < 13; i++)
			check_reg(10 + i, $sformatf("load f3 %0d at +%0d", ld_f3[i], ld_off[i]),
				load_ref(ld_f3[i], ld_off[i]));
		end_test("load_store");
	endtask

	task automatic test_jump_branch();
		begin_test();
		fall_count = 0;
		j_type(1, 8);
		addi(31, 31, 1); // skipped by jal
		addi(5, 0, 21);
		i_type(OP_JALR, 0, 2, 5, 0); // odd target, bit 0 dropped
		addi(31, 31, 1); // skipped by jalr
		load_const(6, 32'h8000_0000);
		load_const(7, 32'h7fff_ffff);
		load_const(8, 32'hffff_ffff);
		load_const(9, 32'h0000_0001);
		branch_case(0, 6, 32'h8000_0000, 6, 32'h8000_0000);
		branch_case(0, 6, 32'h8000_0000, 7, 32'h7fff_ffff);
		branch_case(1, 6, 32'h8000_0000, 7, 32'h7fff_ffff);
		branch_case(1, 8, 32'hffff_ffff, 8, 32'hffff_ffff);
		branch_case(4, 6, 32'h8000_0000, 7, 32'h7fff_ffff);
		branch_case(4, 7, 32'h7fff_ffff, 6, 32'h8000_0000);
		branch_case(5, 7, 32'h7fff_ffff, 6, 32'h8000_0000);
		branch_case(5, 8, 32'hffff_ffff, 9, 32'h0000_0001);
		branch_case(6, 7, 32'h7fff_ffff, 6, 32'h8000_0000);
		branch_case(6, 8, 32'hffff_ffff, 9, 32'h0000_0001);
		branch_case(7, 8, 32'hffff_ffff, 9, 32'h0000_0001);
		branch_case(7, 9, 32'h0000_0001, 8, 32'hffff_ffff);
		j_type(0, 0);
		load_program();
		release_and_run(RUN_BR);
		check_reg(1, "jal link", 32'd4);
		check_reg(2, "jalr link", 32'd16);
		check_reg(31, "skipped markers", 32'd0);
		check_reg(30, "fall-through count", fall_count);
		end_test("jump_branch");
	endtask

	task automatic test_x0_upper();
		logic [31:0] u1;
		logic [31:0] u2;
		logic [31:0] auipc_pc;
		begin_test();
		u1 = $random(seed);
		u2 = $random(seed);
		addi(0, 0, 123);
		u_type(OP_LUI, 0, 20'habcde);
		addi(3, 0, 5);
		r_type(0, 0, 0, 3, 3);
		addi(4, 0, 7); // x0 read as an operand after the writes
		u_type(OP_LUI, 1, u1[19:0]);
		auipc_pc = prog.size() * 4;
		u_type(OP_AUIPC, 2, u2[19:0]);
		j_type(0, 0);
		load_program();
		for (int i = 0; i < 32; i++)
			check_reg(i, "reset", 32'd0);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		check("pc", pc, 32'd0); // first cycle out of reset
		repeat (RUN_X0) @(negedge clk);
		check_reg(0, "x0 writes", 32'd0);
		check_reg(1, "lui", {u1[19:0], 12'b0});
		check_reg(2, "auipc", auipc_pc + {u2[19:0], 12'b0});
		check_reg(3, "addi", 32'd5);
		check_reg(4, "x0 operand", 32'd7);
		end_test("x0_upper");
	endtask

	initial
	begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		dbg_addr   = '0;
		seed       = 57;
		cycles     = 0;
		checks     = 0;
		errors     = 0;
		tests      = 0;
		test_alu();
		test_fibonacci();
		test_load_store();
		test_jump_branch();
		test_x0_upper();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core.f
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o tb_rv_core \
	&& ./obj_dir/tb_rv_core > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qF '** FAIL **' sim.log && exit 1
grep -qF '** PASS **' sim.log || exit 1
exit 0
